// ==== cache_pkg.sv ====
// cache geometry constants for the instruction cache
// fetch address split into tag, index, word and byte fields

package cache_pkg;

  // ----------------------------------------------------------------------
  // geometry
  // ----------------------------------------------------------------------

  // byte address space of 16 MB
  localparam int ADDR_W = 24;

  // address field widths
  localparam int TAG_W   = 10;
  localparam int INDEX_W = 9;
  localparam int WORD_W  = 3;
  localparam int BYTE_W  = 2;

  // 8 words of 32 bits per line
  localparam int LINE_WORDS = 8;

  // 512 lines give 16 KB in total
  localparam int NUM_LINES = 512;

  // ----------------------------------------------------------------------
  // address layout
  // ----------------------------------------------------------------------

  // tag | index | word | byte, msb first
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic [WORD_W-1:0]  word;
    // byte offset inside a word, ignored by the cache
    logic [BYTE_W-1:0]  byte_off;
  } fetch_addr_t;

endpackage

// ==== bus_pkg.sv ====
// memory request and response structs for line fills
// program load write and fetched instruction structs

package bus_pkg;

  import cache_pkg::*;

  // instruction word width
  localparam int DATA_W = 32;

  // word address, byte bits dropped
  localparam int WADDR_W = ADDR_W - BYTE_W;

  // line fill request from the cache
  typedef struct packed {
    logic               stb;
    logic [WADDR_W-1:0] addr;
  } mem_req_t;

  // one burst beat back to the cache
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] data;
  } mem_rsp_t;

  // program load port of the memory
  typedef struct packed {
    logic               we;
    logic [WADDR_W-1:0] addr;
    logic [DATA_W-1:0]  data;
  } load_t;

  // fetched instruction tagged with its pc
  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] word;
  } instr_t;

endpackage

// ==== icache.sv ====
// direct-mapped instruction cache, 512 lines of 8 words
// line fill from burst memory and valid sweep after reset

`timescale 1ns/1ns

module icache import cache_pkg::*, bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  // request side
  output logic              req_ready,
  input  logic              req_valid,
  input  fetch_addr_t       req_addr,
  // response side
  input  logic              rsp_ready,
  output logic              rsp_valid,
  output logic [DATA_W-1:0] rsp_data,
  // line fill port
  output mem_req_t          mem_req,
  input  mem_rsp_t          mem_rsp
);

  // request in flight
  logic        valid_q;
  fetch_addr_t addr_q;

  // read and write addressing of the arrays
  logic [INDEX_W-1:0]        rd_index;
  logic [WORD_W-1:0]         rd_word;
  logic [INDEX_W+WORD_W-1:0] rd_slot;
  logic [INDEX_W-1:0]        wr_index;
  logic [INDEX_W+WORD_W-1:0] wr_slot;

  // storage
  logic              valid_arr [NUM_LINES];
  logic [TAG_W-1:0]  tag_arr [NUM_LINES];
  logic [DATA_W-1:0] data_arr [NUM_LINES*LINE_WORDS];

  // registered array outputs
  logic              line_valid_q;
  logic [TAG_W-1:0]  line_tag_q;
  logic [DATA_W-1:0] word_q;

  logic hit;

  // fill control
  logic [WORD_W-1:0] fill_cnt;
  logic              ack_q;
  logic              rd_again;

  // invalidation sweep, msb set when done
  logic [INDEX_W:0] sweep_cnt;
  logic             sweeping;

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------

  // a new address only goes in once the current response is gone
  assign req_ready = rsp_ready & (hit | ~valid_q) & ~sweeping;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (req_ready) begin
      valid_q <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready) begin
      addr_q <= req_addr;
    end
  end

  assign rsp_valid = valid_q & hit;
  assign rsp_data  = word_q;

  // ----------------------------------------------------------------------
  // arrays
  // ----------------------------------------------------------------------

  // after a fill the stored address is read once more
  assign rd_index = rd_again ? addr_q.index : req_addr.index;
  assign rd_word  = rd_again ? addr_q.word : req_addr.word;
  assign rd_slot  = {rd_index, rd_word};

  assign wr_index = sweeping ? sweep_cnt[INDEX_W-1:0] : addr_q.index;
  assign wr_slot  = {addr_q.index, fill_cnt};

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid_q <= 1'b0;
    end else if (req_ready || rd_again) begin
      line_valid_q <= valid_arr[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready || rd_again) begin
      line_tag_q <= tag_arr[rd_index];
      word_q     <= data_arr[rd_slot];
    end
    // sweep clears flags and every fill beat sets one
    if (mem_rsp.ack || sweeping) begin
      valid_arr[wr_index] <= ~sweeping;
    end
    if (mem_rsp.ack) begin
      tag_arr[addr_q.index] <= addr_q.tag;
      data_arr[wr_slot]     <= mem_rsp.data;
    end
  end

  // ----------------------------------------------------------------------
  // miss handling
  // ----------------------------------------------------------------------

  assign hit = line_valid_q & (line_tag_q == addr_q.tag);

  // strobe drops once the burst has started
  assign mem_req.stb  = ~hit & valid_q & ~ack_q;
  assign mem_req.addr = {addr_q.tag, addr_q.index, {WORD_W{1'b0}}};

  // beats arrive in ascending word order
  always_ff @(posedge clk) begin
    if (rst || !mem_rsp.ack) begin
      fill_cnt <= '0;
    end else begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= mem_rsp.ack;
    end
  end

  // first cycle after the last beat
  assign rd_again = ~mem_rsp.ack & ack_q;

  // ----------------------------------------------------------------------
  // invalidation sweep
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      sweep_cnt <= '0;
    end else if (!sweep_cnt[INDEX_W]) begin
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  assign sweeping = ~sweep_cnt[INDEX_W];

endmodule

// ==== fetch_seq.sv ====
// fetch sequencer holding the program counter
// redirect handling and discard of stale responses

`timescale 1ns/1ns

module fetch_seq import cache_pkg::*, bus_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              redirect,
  input  fetch_addr_t       target,
  input  logic              out_ready,
  // cache request side
  input  logic              req_ready,
  output logic              req_valid,
  output fetch_addr_t       req_addr,
  // cache response side
  input  logic              rsp_valid,
  input  logic [DATA_W-1:0] rsp_data,
  output logic              rsp_ready,
  // consumer
  output logic              out_valid,
  output instr_t            out_instr
);

  fetch_addr_t       pc_q;
  fetch_addr_t       target_word;
  logic              running_q;
  // pc of the request in flight and whether it still counts
  logic [ADDR_W-1:0] inflight_pc;
  logic              inflight_live;

  // targets are forced to a word boundary
  always_comb begin
    target_word          = target;
    target_word.byte_off = '0;
  end

  // no request goes out on the redirect cycle itself
  assign req_valid = running_q & ~redirect;
  assign req_addr  = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q          <= '0;
      running_q     <= 1'b0;
      inflight_live <= 1'b0;
    end else if (redirect) begin
      pc_q          <= target_word;
      running_q     <= 1'b1;
      // anything still outstanding belongs to the old stream
      inflight_live <= 1'b0;
    end else if (req_ready) begin
      inflight_live <= req_valid;
      if (req_valid) begin
        // one word per accepted fetch
        pc_q <= fetch_addr_t'(pc_q + ADDR_W'(4));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready && req_valid) begin
      inflight_pc <= pc_q;
    end
  end

  // stale responses are consumed but never shown
  assign rsp_ready = out_ready;
  assign out_valid = rsp_valid & inflight_live & ~redirect;
  assign out_instr = '{pc: inflight_pc, word: rsp_data};

endmodule

// ==== burst_mem.sv ====
// word memory with a load port for the program
// answers line fill strobes with bursts of 8 beats

`timescale 1ns/1ns

module burst_mem import cache_pkg::*, bus_pkg::*; #(
  parameter int MEM_LATENCY = 4,
  parameter int MEM_WORDS   = 4096
) (
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp,
  input  load_t    load
);

  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam int LAT_W     = $clog2(MEM_LATENCY + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_BURST,
    S_GAP
  } state_t;

  state_t             state_q;
  logic [LAT_W-1:0]   lat_cnt;
  logic [WORD_W-1:0]  beat_cnt;
  logic [WADDR_W-1:0] addr_q;

  logic [DATA_W-1:0]    mem [MEM_WORDS];
  logic [WADDR_W-1:0]   base;
  logic [WORD_W-1:0]    next_beat;
  logic [MEM_IDX_W-1:0] rd_idx;
  logic [MEM_IDX_W-1:0] wr_idx;
  logic [DATA_W-1:0]    rd_data_q;

  // ----------------------------------------------------------------------
  // burst FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= S_IDLE;
      lat_cnt  <= '0;
      beat_cnt <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (mem_req.stb) begin
            lat_cnt  <= LAT_W'(1);
            beat_cnt <= '0;
            state_q  <= (MEM_LATENCY <= 1) ? S_BURST : S_WAIT;
          end
        end
        S_WAIT: begin
          if (lat_cnt == LAT_W'(MEM_LATENCY - 1)) begin
            state_q <= S_BURST;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        S_BURST: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == WORD_W'(LINE_WORDS - 1)) begin
            state_q <= S_GAP;
          end
        end
        // one cycle where the strobe is not looked at
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && mem_req.stb) begin
      addr_q <= mem_req.addr;
    end
  end

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------

  // data for each beat is read one cycle ahead of its ack
  assign base      = (state_q == S_IDLE) ? mem_req.addr : addr_q;
  assign next_beat = (state_q == S_BURST) ? beat_cnt + 1'b1 : '0;
  assign rd_idx    = MEM_IDX_W'((32'(base) + 32'(next_beat)) % MEM_WORDS);
  assign wr_idx    = MEM_IDX_W'(32'(load.addr) % MEM_WORDS);

  always_ff @(posedge clk) begin
    if (load.we) begin
      mem[wr_idx] <= load.data;
    end
    rd_data_q <= mem[rd_idx];
  end

  assign mem_rsp.ack  = (state_q == S_BURST);
  assign mem_rsp.data = rd_data_q;

endmodule

// ==== ifetch_top.sv ====
// instruction fetch top level
// sequencer, instruction cache and burst memory

`timescale 1ns/1ns

module ifetch_top import cache_pkg::*, bus_pkg::*; #(
  parameter int MEM_LATENCY = 4,
  parameter int MEM_WORDS   = 4096
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        redirect,
  input  fetch_addr_t target,
  input  logic        out_ready,
  input  load_t       load,
  output logic        out_valid,
  output instr_t      out_instr
);

  // sequencer to cache
  logic              req_ready;
  logic              req_valid;
  fetch_addr_t       req_addr;
  logic              rsp_valid;
  logic [DATA_W-1:0] rsp_data;
  logic              rsp_ready;

  // cache to memory
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  fetch_seq u_seq (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .target    (target),
    .out_ready (out_ready),
    .req_ready (req_ready),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_ready (rsp_ready),
    .out_valid (out_valid),
    .out_instr (out_instr)
  );

  icache u_cache (
    .clk       (clk),
    .rst       (rst),
    .req_ready (req_ready),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .rsp_ready (rsp_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp)
  );

  burst_mem #(
    .MEM_LATENCY (MEM_LATENCY),
    .MEM_WORDS   (MEM_WORDS)
  ) u_mem (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp),
    .load    (load)
  );

endmodule

// ==== tb_ifetch.sv ====
// testbench for the instruction fetch top level
// random program load, reference model and per-test checks

`timescale 1ns/1ns

module tb_ifetch import cache_pkg::*, bus_pkg::*; ();

  localparam int MEM_WORDS = 4096;

  logic        clk;
  logic        rst;
  logic        redirect;
  fetch_addr_t target;
  logic        out_ready;
  load_t       load;
  logic        out_valid;
  instr_t      out_instr;

  // reference model and captured outputs
  logic [DATA_W-1:0] model [MEM_WORDS];
  instr_t            got_q [$];
  int                stamp_q [$];

  string       test_name;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          test_err_start;
  int          cycle_cnt;
  int          wait_cycles;
  logic        hold_pending;
  instr_t      held_instr;
  logic        random_ready;
  logic        load_done;
  logic [23:0] addr_a;
  logic [23:0] addr_b;
  logic [23:0] tgt;

  ifetch_top #(
    .MEM_LATENCY (4),
    .MEM_WORDS   (MEM_WORDS)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .target    (target),
    .out_ready (out_ready),
    .load      (load),
    .out_valid (out_valid),
    .out_instr (out_instr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // consumer ready, either always high or random per cycle
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      out_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, expected,
               actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_start = errors;
  endtask

  task automatic end_test();
    if (errors == test_err_start) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - test_err_start);
    end
  endtask

  // writes the whole model into memory, one word per cycle
  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      #1;
      load.we   = 1'b1;
      load.addr = WADDR_W'(i);
      load.data = model[i];
    end
    @(posedge clk);
    #1;
    load.we   = 1'b0;
    load_done = 1'b1;
  endtask

  // one-cycle redirect pulse, older outputs are forgotten
  task automatic redirect_to(input logic [23:0] addr);
    @(posedge clk);
    #1;
    redirect = 1'b1;
    target   = fetch_addr_t'(addr);
    got_q.delete();
    stamp_q.delete();
    @(posedge clk);
    #1;
    redirect = 1'b0;
  endtask

  // waits for n outputs and compares them with the walked pc sequence
  task automatic compare_stream(input logic [23:0] start, input int n);
    logic [23:0] exp_q [$];
    logic [23:0] pc;
    int          cycles;
    int          err_before;
    cycles = 0;
    while (got_q.size() < n && cycles < 200 + 40 * n) begin
      @(posedge clk);
      cycles++;
    end
    if (got_q.size() < n) begin
      errors++;
      $display("ERROR: %s timed out after %0d cycles with %0d of %0d outputs", test_name,
               cycles, got_q.size(), n);
      return;
    end
    pc = start & 24'hfffffc;
    for (int i = 0; i < n; i++) begin
      exp_q.push_back(pc);
      pc = pc + 24'd4;
    end
    err_before = errors;
    for (int i = 0; i < n && errors == err_before; i++) begin
      check("pc", exp_q[i], got_q[i].pc);
      check("word", model[(exp_q[i] >> 2) % MEM_WORDS], got_q[i].word);
    end
  endtask

  // ----------------------------------------------------------------------
  // output monitor, sampled on the falling edge
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      cycle_cnt    = 0;
      hold_pending = 1'b0;
    end else begin
      cycle_cnt++;
      // a stalled response must not move until it is taken
      if (hold_pending && !redirect) begin
        check("held valid", 1, out_valid);
        check("held instr", held_instr, out_instr);
      end
      hold_pending = out_valid && !out_ready;
      held_instr   = out_instr;
      if (out_valid && out_ready) begin
        got_q.push_back(out_instr);
        stamp_q.push_back(cycle_cnt);
      end
    end
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin
    void'($urandom(97227));
    rst          = 1'b1;
    redirect     = 1'b0;
    target       = '0;
    load         = '0;
    random_ready = 1'b0;
    load_done    = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name    = "setup";
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = $urandom;
    end
    // loader runs ahead of the first fetches from address 0
    fork
      load_program();
    join_none
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("reset_sweep");
    redirect_to(24'h000000);
    wait_cycles = 0;
    while (got_q.size() == 0 && wait_cycles < 2000) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (got_q.size() == 0) begin
      errors++;
      $display("ERROR: no output appeared within 2000 cycles after the first redirect");
    end else if (stamp_q[0] < 512) begin
      errors++;
      $display("ERROR: first output came %0d cycles after reset, inside the sweep",
               stamp_q[0]);
    end
    compare_stream(24'h000000, 16);
    end_test();

    wait_cycles = 0;
    while (!load_done && wait_cycles < 5000) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (!load_done) begin
      errors++;
      $display("ERROR: program load did not finish within 5000 cycles");
    end

    begin_test("sequential");
    tgt = 24'($urandom);
    redirect_to(tgt);
    compare_stream(tgt, 200);
    end_test();

    begin_test("random_redirect");
    for (int r = 0; r < 20; r++) begin
      tgt = 24'($urandom);
      redirect_to(tgt);
      compare_stream(tgt, $urandom_range(1, 6));
      repeat ($urandom_range(0, 3)) @(posedge clk);
    end
    end_test();

    begin_test("loop_hits");
    tgt = 24'($urandom) & 24'hffffe0;
    redirect_to(tgt);
    compare_stream(tgt, 32);
    // second pass over the same lines
    redirect_to(tgt);
    compare_stream(tgt, 32);
    for (int i = 1; i < 32 && i < stamp_q.size(); i++) begin
      check("hit spacing", 1, stamp_q[i] - stamp_q[i-1]);
    end
    end_test();

    begin_test("back_pressure");
    random_ready = 1'b1;
    tgt = 24'($urandom);
    redirect_to(tgt);
    compare_stream(tgt, 200);
    random_ready = 1'b0;
    end_test();

    begin_test("conflict_evict");
    // same index, different tag and word
    addr_a = 24'($urandom) & 24'hfffffc;
    addr_b = {~addr_a[23:14], addr_a[13:5], 3'($urandom), 2'b00};
    for (int r = 0; r < 8; r++) begin
      redirect_to(addr_a);
      compare_stream(addr_a, 1);
      redirect_to(addr_b);
      compare_stream(addr_b, 1);
    end
    end_test();

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== all.f ====
cache_pkg.sv
bus_pkg.sv
icache.sv
fetch_seq.sv
burst_mem.sv
ifetch_top.sv
tb_ifetch.sv

// ==== Bender.yml ====
package:
  name: ifetch

sources:
  - cache_pkg.sv
  - bus_pkg.sv
  - icache.sv
  - fetch_seq.sv
  - burst_mem.sv
  - ifetch_top.sv
  - target: test
    files:
      - tb_ifetch.sv
